//--- sim.f
+incdir+logic
logic/cpu_pkg.sv
logic/cpu_ctrl_if.sv
logic/cpu_sequencer.sv
logic/cpu_fetch_unit.sv
logic/cpu_alu_acc.sv
logic/cpu_top.sv
dv/cpu_chk.sv
dv/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/cpu_pkg.sv
      - logic/cpu_ctrl_if.sv
      - logic/cpu_sequencer.sv
      - logic/cpu_fetch_unit.sv
      - logic/cpu_alu_acc.sv
      - logic/cpu_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - dv/cpu_chk.sv
      - dv/cpu_tb.sv

//--- dv/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_tb;

  localparam int MEM_BYTES     = 1 << `CPU_ADDR_W;
  localparam int STORE_TIMEOUT = 200;  // max cycles between stores
  localparam int QUIET_CYCLES  = 150;  // watch for stray stores at the end
  localparam int MODEL_STEPS   = 64;   // instruction limit of the model

  logic                   clk;
  logic                   rst_n;
  logic [`CPU_ADDR_W-1:0] mem_addr;
  logic                   mem_rd;
  logic                   mem_wr;
  logic [`CPU_DATA_W-1:0] mem_wdata;
  logic [`CPU_DATA_W-1:0] mem_rdata;

  logic [`CPU_DATA_W-1:0] mem     [0:MEM_BYTES-1];  // seen by the DUT
  logic [`CPU_DATA_W-1:0] ref_mem [0:MEM_BYTES-1];  // model copy
  logic [`CPU_ADDR_W-1:0] exp_addr_q[$];            // expected stores
  logic [`CPU_DATA_W-1:0] exp_data_q[$];

  cpu_top cpu_top_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_addr  (mem_addr),
    .mem_rd    (mem_rd),
    .mem_wr    (mem_wr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

  bind cpu_top cpu_chk chk_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .mem_rd   (mem_rd),
    .mem_wr   (mem_wr),
    .mem_addr (mem_addr),
    .a_sel    (ctrl_if.a_sel)  // internal select of the address mux
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic put_byte(input logic [`CPU_ADDR_W-1:0] at, input logic [`CPU_DATA_W-1:0] b);
    mem[at]     = b;
    ref_mem[at] = b;
  endtask

  task automatic put_instr(input logic [`CPU_ADDR_W-1:0] at, input cpu_pkg::opcode_e op,
                           input logic [`CPU_ADDR_W-1:0] opnd);
    logic [`CPU_INSTR_W-1:0] word;
    word = {op, opnd};
    put_byte(at, word[15:8]);         // high byte fetched first
    put_byte(at + 1'b1, word[7:0]);
  endtask

  task automatic load_memory();
    logic [`CPU_ADDR_W-1:0] ad;
    for (int a = 0; a < MEM_BYTES; a++) begin
      ad = `CPU_ADDR_W'(a);
      put_byte(ad, ad[7:0] ^ {3'b000, ad[12:8]} ^ 8'h5a);  // whole-address fill
    end
    put_byte(13'h100, 8'h3c);                    // fixed load value
    put_byte(13'h101, 8'($urandom()));           // add operand
    put_byte(13'h102, 8'($urandom()));           // nxor pair
    put_byte(13'h103, 8'($urandom()));
    put_byte(13'h104, 8'($urandom()));           // rotate source
    put_byte(13'h105, 8'h11);
    put_instr(13'h000, cpu_pkg::LDA,  13'h100);
    put_instr(13'h002, cpu_pkg::STO,  13'h200);
    put_instr(13'h004, cpu_pkg::ADD,  13'h101);
    put_instr(13'h006, cpu_pkg::STO,  13'h201);
    put_instr(13'h008, cpu_pkg::LDA,  13'h102);
    put_instr(13'h00a, cpu_pkg::NXOR, 13'h103);
    put_instr(13'h00c, cpu_pkg::STO,  13'h202);
    put_instr(13'h00e, cpu_pkg::SFT,  13'h104);
    put_instr(13'h010, cpu_pkg::STO,  13'h203);
    put_instr(13'h012, cpu_pkg::NOP,  13'h000);
    put_instr(13'h014, cpu_pkg::STO,  13'h204);  // acc after nop
    put_instr(13'h016, cpu_pkg::SKP,  13'h000);
    put_instr(13'h018, cpu_pkg::STO,  13'h205);  // skipped
    put_instr(13'h01a, cpu_pkg::STO,  13'h206);
    put_instr(13'h01c, cpu_pkg::JMP,  13'h040);
    put_instr(13'h01e, cpu_pkg::STO,  13'h207);  // jumped over
    put_instr(13'h040, cpu_pkg::ADD,  13'h105);
    put_instr(13'h042, cpu_pkg::STO,  13'h208);
    put_instr(13'h044, cpu_pkg::JMP,  13'h044);  // park here
  endtask

  // instruction level walk of the program
  task automatic build_expected();
    logic [`CPU_ADDR_W-1:0] pc;
    logic [`CPU_DATA_W-1:0] acc;
    logic [`CPU_DATA_W-1:0] hi;
    logic [`CPU_DATA_W-1:0] lo;
    logic [`CPU_DATA_W-1:0] opnd;
    logic [`CPU_ADDR_W-1:0] addr;
    logic                   halted;
    int                     n;
    pc     = '0;
    acc    = '0;
    halted = 1'b0;
    n      = 0;
    while (!halted && n < MODEL_STEPS) begin
      hi   = ref_mem[pc];
      lo   = ref_mem[pc + 1'b1];
      addr = {hi[4:0], lo};
      opnd = ref_mem[addr];
      case (cpu_pkg::opcode_e'(hi[7:5]))
        cpu_pkg::LDA:  acc = opnd;
        cpu_pkg::ADD:  acc = acc + opnd;             // wraps at 256
        cpu_pkg::NXOR: acc = ~(acc ^ opnd);
        cpu_pkg::SFT:  acc = {opnd[6:0], opnd[7]};   // rotate left
        cpu_pkg::STO: begin
          exp_addr_q.push_back(addr);
          exp_data_q.push_back(acc);
          ref_mem[addr] = acc;
        end
        default: ;
      endcase
      if (hi[7:5] == cpu_pkg::JMP && addr == pc) begin
        halted = 1'b1;                               // jump to itself
      end else if (hi[7:5] == cpu_pkg::JMP) begin
        pc = addr;
      end else if (hi[7:5] == cpu_pkg::SKP) begin
        pc = pc + 13'd4;                             // this one and the next
      end else begin
        pc = pc + 13'd2;
      end
      n++;
    end
  endtask

  task automatic check_store(input logic [`CPU_ADDR_W-1:0] addr,
                             input logic [`CPU_DATA_W-1:0] data);
    logic [`CPU_ADDR_W-1:0] exp_a;
    logic [`CPU_DATA_W-1:0] exp_d;
    $display("store mem[%h] <= %h", addr, data);
    if (exp_addr_q.size() == 0) begin
      fail_run($sformatf("store to %h seen but none was expected", addr));
    end else begin
      exp_a = exp_addr_q.pop_front();
      exp_d = exp_data_q.pop_front();
      assert (addr == exp_a)
        else fail_run($sformatf("Mismatch mem_addr: got %h, expected %h", addr, exp_a));
      assert (data == exp_d)
        else fail_run($sformatf("Mismatch mem_wdata: got %h, expected %h", data, exp_d));
    end
  endtask

  // synchronous memory with one cycle read latency
  always @(posedge clk) begin
    if (rst_n && mem_rd) begin
      mem_rdata <= mem[mem_addr];
    end
    if (rst_n && mem_wr) begin
      check_store(mem_addr, mem_wdata);
      mem[mem_addr] = mem_wdata;
    end
  end

  // bound checker assertion count
  always @(negedge clk) begin
    if (cpu_top_i.chk_i.fail_cnt != 0) begin
      fail_run("a bus rule assertion in the checker failed");
    end
  end

  initial begin
    int unsigned seed_ret;
    int          wait_cnt;
    int          left;
    seed_ret  = $urandom(97);  // seeds the generator
    rst_n     = 1'b0;
    mem_rdata = '0;
    load_memory();
    build_expected();
    $display("expecting %0d stores", exp_addr_q.size());
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    // each store must arrive within the timeout
    wait_cnt = 0;
    left     = exp_addr_q.size();
    while (exp_addr_q.size() != 0) begin
      @(posedge clk);
      wait_cnt++;
      if (exp_addr_q.size() != left) begin
        left     = exp_addr_q.size();
        wait_cnt = 0;
      end else if (wait_cnt > STORE_TIMEOUT) begin
        fail_run($sformatf("no store seen for %0d cycles, %0d still expected",
                           STORE_TIMEOUT, left));
      end
    end

    // quiet window while the program is parked
    wait_cnt = 0;
    while (wait_cnt < QUIET_CYCLES) begin
      @(posedge clk);
      wait_cnt++;
    end

    @(negedge clk);
    if (cpu_top_i.chk_i.fail_cnt != 0) begin
      fail_run("a bus rule assertion in the checker failed");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

//--- dv/cpu_chk.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_chk (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   mem_rd,
  input logic                   mem_wr,
  input logic [`CPU_ADDR_W-1:0] mem_addr,
  input logic                   a_sel     // 0 while fetching from pc
);

  int unsigned fail_cnt = 0;  // assertion failures so far
  logic        fetch_rd;      // read with pc as address

  assign fetch_rd = mem_rd && !a_sel;

  // quiet bus through reset
  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |-> (!mem_rd && !mem_wr))
    else begin $error("bus strobe active during reset"); fail_cnt++; end

  // and in the first cycles after release
  a_release_quiet: assert property (@(posedge clk)
    $rose(rst_n) |-> (!mem_rd && !mem_wr) ##1 (!mem_rd && !mem_wr))
    else begin $error("bus strobe active right after reset"); fail_cnt++; end

  // one direction at a time
  a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(mem_rd && mem_wr))
    else begin $error("mem_rd and mem_wr high together"); fail_cnt++; end

  // store strobe is a single pulse
  a_wr_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    mem_wr |=> !mem_wr)
    else begin $error("mem_wr held longer than one cycle"); fail_cnt++; end

  // high byte then low byte then a gap
  a_fetch_pair: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(fetch_rd) |=> (fetch_rd && (mem_addr == $past(mem_addr) + 1'b1)) ##1 !fetch_rd)
    else begin $error("fetch reads not a consecutive pair"); fail_cnt++; end

endmodule

//--- logic/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_top (
  input  logic                   clk,
  input  logic                   rst_n,
  output logic [`CPU_ADDR_W-1:0] mem_addr,   // byte address
  output logic                   mem_rd,     // read, data one cycle later
  output logic                   mem_wr,     // single cycle write
  output logic [`CPU_DATA_W-1:0] mem_wdata,  // accumulator
  input  logic [`CPU_DATA_W-1:0] mem_rdata
);

  // datapath control strobes
  cpu_ctrl_if ctrl_if ();

  // instruction cycle timing and decode
  cpu_sequencer seq_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .ctrl   (ctrl_if.seq),
    .mem_rd (mem_rd),
    .mem_wr (mem_wr)
  );

  // pc, ir, address mux
  cpu_fetch_unit fetch_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl      (ctrl_if.fetch),
    .mem_rdata (mem_rdata),
    .mem_addr  (mem_addr)
  );

  // alu and accumulator
  cpu_alu_acc alu_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl      (ctrl_if.alu),
    .mem_rdata (mem_rdata),
    .acc       (mem_wdata)  // acc drives store data
  );

endmodule

//--- logic/cpu_alu_acc.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_alu_acc (
  input  logic                   clk,
  input  logic                   rst_n,
  cpu_ctrl_if.alu                ctrl,
  input  logic [`CPU_DATA_W-1:0] mem_rdata,  // operand byte in step 6
  output logic [`CPU_DATA_W-1:0] acc         // also the store data
);

  logic [`CPU_DATA_W-1:0] alu_nxt;  // combinational result
  logic [`CPU_DATA_W-1:0] alu_q;    // captured on en_alu

  // result select by opcode
  always_comb begin
    case (ctrl.opcode)
      cpu_pkg::LDA: begin
        alu_nxt = mem_rdata;  // plain load
      end
      cpu_pkg::ADD: begin
        alu_nxt = acc + mem_rdata;  // carry dropped
      end
      cpu_pkg::NXOR: begin
        alu_nxt = ~(acc ^ mem_rdata);
      end
      cpu_pkg::SFT: begin
        // rotate left by one
        alu_nxt = {mem_rdata[`CPU_DATA_W-2:0], mem_rdata[`CPU_DATA_W-1]};
      end
      default: begin
        alu_nxt = acc;  // no acc change
      end
    endcase
  end

  // result register
  always_ff @(posedge clk) begin
    if (ctrl.en_alu) begin
      alu_q <= alu_nxt;
    end
  end

  // accumulator, loads one step after capture
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc <= '0;
    end else if (ctrl.ld_acc) begin
      acc <= alu_q;
    end
  end

endmodule

//--- logic/cpu_fetch_unit.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_fetch_unit (
  input  logic                   clk,
  input  logic                   rst_n,
  cpu_ctrl_if.fetch              ctrl,
  input  logic [`CPU_DATA_W-1:0] mem_rdata,  // instruction bytes arrive here
  output logic [`CPU_ADDR_W-1:0] mem_addr
);

  logic [`CPU_ADDR_W-1:0]  pc;         // program counter
  logic [`CPU_INSTR_W-1:0] ir;         // instruction register
  logic [`CPU_ADDR_W-1:0]  opnd_addr;  // operand address field

  // low bits of the instruction hold the address
  assign opnd_addr = ir[`CPU_ADDR_W-1:0];

  // program counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (ctrl.ld_pc) begin
      pc <= opnd_addr;  // jump
    end else if (ctrl.en_inc) begin
      pc <= pc + 1'b1;  // fetch bytes, skip
    end
  end

  // instruction register, high byte shifted in first
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ir <= '0;  // decodes as NOP
    end else if (ctrl.ld_ir) begin
      ir <= {ir[`CPU_INSTR_W-`CPU_DATA_W-1:0], mem_rdata};
    end
  end

  // opcode field back to sequencer and alu
  assign ctrl.opcode = cpu_pkg::opcode_e'(ir[`CPU_INSTR_W-1:`CPU_ADDR_W]);

  // address mux
  assign mem_addr = ctrl.a_sel ? opnd_addr : pc;

endmodule

//--- logic/cpu_sequencer.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_sequencer (
  input  logic       clk,
  input  logic       rst_n,
  cpu_ctrl_if.seq    ctrl,
  output logic       mem_rd,   // fetch or operand read
  output logic       mem_wr    // store strobe
);

  localparam int DIV_W = (`CPU_PHASE_DIV > 1) ? $clog2(`CPU_PHASE_DIV) : 1;

  logic [DIV_W-1:0] div_cnt;   // phase divider count
  logic             phase;     // slow phase level, gates step 0
  cpu_pkg::step_t   step;      // instruction cycle step
  logic             fetch_rd;  // one of the two fetch reads
  logic             alu_op;    // opcode reads an operand
  logic             rd_exec;   // registered operand read

  // phase divider
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
      phase   <= 1'b0;
    end else if (div_cnt == DIV_W'(`CPU_PHASE_DIV - 1)) begin
      div_cnt <= '0;
      phase   <= ~phase;  // toggle every CPU_PHASE_DIV clocks
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // step counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      step <= 3'd0;
    end else if (step == 3'd0) begin
      if (phase) begin
        step <= 3'd1;  // leave idle step on high phase
      end
    end else begin
      step <= step + 3'd1;  // 7 wraps to 0
    end
  end

  // operand access group, shares the read and acc load path
  assign alu_op = ctrl.opcode inside {cpu_pkg::LDA, cpu_pkg::ADD,
                                      cpu_pkg::NXOR, cpu_pkg::SFT};

  // fetch reads in the cycle leaving step 0 and in step 1
  assign fetch_rd = ((step == 3'd0) && phase) || (step == 3'd1);

  // decoded in step 4, read goes out in step 5
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_exec <= 1'b0;
    end else begin
      rd_exec <= alu_op && (step == 3'd4);
    end
  end

  // decoded in step 6, acc loads in step 7
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl.ld_acc <= 1'b0;
    end else begin
      ctrl.ld_acc <= alu_op && (step == 3'd6);
    end
  end

  // memory strobes
  assign mem_rd = fetch_rd | rd_exec;
  assign mem_wr = (ctrl.opcode == cpu_pkg::STO) && (step == 3'd7);  // acc out on wdata

  // fetch side strobes
  assign ctrl.ld_ir  = (step == 3'd1) || (step == 3'd2);  // byte lands one cycle after rd
  assign ctrl.a_sel  = ~fetch_rd;  // operand address outside fetch

  // pc steps on both fetch reads, SKP adds two more
  assign ctrl.en_inc = fetch_rd ||
                       ((ctrl.opcode == cpu_pkg::SKP) &&
                        ((step == 3'd6) || (step == 3'd7)));

  assign ctrl.ld_pc  = (ctrl.opcode == cpu_pkg::JMP) && (step == 3'd7);

  // operand byte valid in step 6
  assign ctrl.en_alu = alu_op && (step == 3'd6);

endmodule

//--- logic/cpu_ctrl_if.sv
`timescale 1ns/1ps

interface cpu_ctrl_if;

  logic               en_inc;  // pc + 1
  logic               ld_pc;   // pc <= operand address
  logic               ld_ir;   // shift read byte into ir
  logic               a_sel;   // 0 pc, 1 operand address
  logic               en_alu;  // capture alu result
  logic               ld_acc;  // acc <= alu result
  cpu_pkg::opcode_e   opcode;  // decoded from ir high bits

  // sequencer drives every strobe, reads opcode back
  modport seq (
    output en_inc, ld_pc, ld_ir, a_sel, en_alu, ld_acc,
    input  opcode
  );

  // pc, ir, address mux
  modport fetch (
    input  en_inc, ld_pc, ld_ir, a_sel,
    output opcode
  );

  // alu result and accumulator
  modport alu (
    input en_alu, ld_acc, opcode
  );

endinterface

//--- logic/cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

  // opcode sits above the operand address in the instruction word
  typedef enum logic [`CPU_INSTR_W-`CPU_ADDR_W-1:0] {
    NOP  = 3'b000,  // no operation
    LDA  = 3'b001,  // acc <= mem[addr]
    STO  = 3'b010,  // mem[addr] <= acc
    ADD  = 3'b011,  // acc <= acc + mem[addr]
    NXOR = 3'b100,  // acc <= ~(acc ^ mem[addr])
    SFT  = 3'b101,  // acc <= rotl(mem[addr])
    SKP  = 3'b110,  // skip next instruction
    JMP  = 3'b111   // pc <= addr
  } opcode_e;

  // eight steps per instruction cycle
  typedef logic [2:0] step_t;

endpackage

//--- logic/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// core widths
`define CPU_DATA_W    8   // data bus, accumulator
`define CPU_ADDR_W    13  // program counter, operand address
`define CPU_INSTR_W   16  // opcode plus operand address

// sequencer phase level toggles after this many clocks
`define CPU_PHASE_DIV 4

`endif
